// ==== src/video_pkg.sv ====
// shared pixel, bank word and raster control types; every RTL file imports this package
package video_pkg;

   //////////////////////////////////////////////////////////////
   // pixel format
   //////////////////////////////////////////////////////////////

   // six bits kept per color channel
   localparam int CH_W = 6;

   // one displayed pixel, 18 bits
   typedef struct packed {
      logic [CH_W-1:0] r;
      logic [CH_W-1:0] g;
      logic [CH_W-1:0] b;
   } pixel_t;

   // one bank word holds a horizontal pair
   // hi is the even (left) pixel, lo the odd one
   typedef struct packed {
      pixel_t hi;
      pixel_t lo;
   } word_t;

   //////////////////////////////////////////////////////////////
   // raster controls
   //////////////////////////////////////////////////////////////

   // syncs are active low, blank is active high
   typedef struct packed {
      logic hsync;
      logic vsync;
      logic blank;
   } sync_t;

   // idle raster state, used out of reset
   localparam sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, blank: 1'b1};

   // hardwired bars: drop 2 column bits, so each bar is 4 pixels wide
   localparam int BAR_SHIFT = 2;
   // bar index width, placed in the top bits of each channel
   localparam int BAR_W = 3;

endpackage

// ==== src/video_if.sv ====
// raster timing bundle and frame bank port bundle connecting the video blocks
`timescale 1ns/1ns

//////////////////////////////////////////////////////////////
// raster timing, driven by the timing generator
//////////////////////////////////////////////////////////////

interface raster_if
   import video_pkg::*;
   #(
      parameter int HW = 5,
      parameter int VW = 4
   ) ();

   // column and line counters
   logic [HW-1:0] hcount;
   logic [VW-1:0] vcount;
   // syncs and blank, aligned with the counters
   sync_t         sync;
   // one cycle at column 0 of line 0
   logic          frame_start;

   modport source (output hcount, vcount, sync, frame_start);
   modport sink (input hcount, vcount, sync, frame_start);

endinterface

//////////////////////////////////////////////////////////////
// bank port, one per side of the ping-pong buffer
//////////////////////////////////////////////////////////////

interface bank_port_if
   import video_pkg::*;
   #(
      parameter int ADDR_W = 6
   ) ();

   logic [ADDR_W-1:0] addr;
   logic              we;
   word_t             wdata;
   // read data, two cycles behind addr
   word_t             rdata;
   // writer has put the last word of a frame
   logic              frame_done;
   // back bank may be filled again
   logic              back_free;

   modport writer (output addr, we, wdata, frame_done, input back_free);
   // read side only, no write strobe
   modport reader (output addr, input rdata);
   modport memory (input addr, we, wdata, frame_done, output rdata, back_free);

endinterface

// ==== src/video_timing.sv ====
// raster generator: column and line counters, active-low syncs, blank and frame-start pulse
`timescale 1ns/1ns

module video_timing
   import video_pkg::*;
   #(
      parameter int H_ACTIVE     = 16,
      parameter int H_SYNC_START = 18,
      parameter int H_SYNC_END   = 20,
      parameter int H_TOTAL      = 24,
      parameter int V_ACTIVE     = 6,
      parameter int V_SYNC_START = 7,
      parameter int V_SYNC_END   = 8,
      parameter int V_TOTAL      = 10
   ) (
      input logic       clk,
      input logic       rst_n,
      raster_if.source  tim
   );

   localparam int HW = $clog2(H_TOTAL);
   localparam int VW = $clog2(V_TOTAL);

   logic [HW-1:0] hcount;
   logic [HW-1:0] h_next;
   logic [VW-1:0] vcount;
   logic [VW-1:0] v_next;
   logic          h_wrap;
   sync_t         sync;
   logic          frame_start;

   // next position, so every registered output lines up with its counter
   always_comb begin
      h_wrap = (hcount == HW'(H_TOTAL - 1));
      h_next = h_wrap ? '0 : hcount + 1'b1;
      v_next = vcount;
      if (h_wrap) begin
         v_next = (vcount == VW'(V_TOTAL - 1)) ? '0 : vcount + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         // park at the last position, first cycle after reset is (0,0)
         hcount      <= HW'(H_TOTAL - 1);
         vcount      <= VW'(V_TOTAL - 1);
         sync        <= SYNC_IDLE;
         frame_start <= 1'b0;
      end else begin
         hcount      <= h_next;
         vcount      <= v_next;
         // hsync low over [H_SYNC_START, H_SYNC_END)
         sync.hsync  <= !(h_next >= H_SYNC_START && h_next < H_SYNC_END);
         // vsync low over whole lines [V_SYNC_START, V_SYNC_END)
         sync.vsync  <= !(v_next >= V_SYNC_START && v_next < V_SYNC_END);
         sync.blank  <= (h_next >= H_ACTIVE) || (v_next >= V_ACTIVE);
         frame_start <= (h_next == '0) && (v_next == '0);
      end
   end

   assign tim.hcount      = hcount;
   assign tim.vcount      = vcount;
   assign tim.sync        = sync;
   assign tim.frame_start = frame_start;

endmodule

// ==== src/pixel_writer.sv ====
// four-phase pixel acceptor that packs pixel pairs and fills the back bank, one frame at a time
`timescale 1ns/1ns

module pixel_writer
   import video_pkg::*;
   #(
      parameter int H_ACTIVE = 16,
      parameter int V_ACTIVE = 6
   ) (
      input  logic        clk,
      input  logic        rst_n,
      input  logic        in_req,
      input  pixel_t      in_pixel,
      output logic        in_ack,
      bank_port_if.writer wr
   );

   localparam int HALF   = H_ACTIVE / 2;
   localparam int WORDS  = HALF * V_ACTIVE;
   localparam int ADDR_W = $clog2(WORDS);

   logic              accept;
   logic              odd;
   logic              we_q;
   logic              done_q;
   logic [ADDR_W-1:0] waddr;
   logic [ADDR_W-1:0] addr_q;
   pixel_t            hold;
   word_t             wdata_q;

   // new request, previous handshake closed, back bank not waiting for a swap
   assign accept = in_req && !in_ack && wr.back_free;

   //////////////////////////////////////////////////////////////
   // handshake and frame position
   //////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_ack <= 1'b0;
         odd    <= 1'b0;
         waddr  <= '0;
         we_q   <= 1'b0;
         done_q <= 1'b0;
      end else begin
         we_q   <= 1'b0;
         done_q <= 1'b0;
         if (accept) begin
            in_ack <= 1'b1;
            odd    <= ~odd;
            // second pixel of a pair completes a word
            if (odd) begin
               we_q <= 1'b1;
               if (waddr == ADDR_W'(WORDS - 1)) begin
                  waddr  <= '0;
                  done_q <= 1'b1;
               end else begin
                  waddr <= waddr + 1'b1;
               end
            end
         end else if (!in_req) begin
            in_ack <= 1'b0;
         end
      end
   end

   // pair buffer and write payload
   always_ff @(posedge clk) begin
      if (accept) begin
         if (!odd) begin
            hold <= in_pixel;
         end else begin
            wdata_q <= '{hi: hold, lo: in_pixel};
            addr_q  <= waddr;
         end
      end
   end

   assign wr.we         = we_q;
   assign wr.addr       = addr_q;
   assign wr.wdata      = wdata_q;
   // lands with the last write of the frame
   assign wr.frame_done = done_q;

endmodule

// ==== src/frame_buffer.sv ====
// ping-pong frame store: two banks, writes to the back one, reads from the front one, swap at frame start
`timescale 1ns/1ns

module frame_buffer
   import video_pkg::*;
   #(
      parameter int H_ACTIVE = 16,
      parameter int V_ACTIVE = 6
   ) (
      input logic         clk,
      input logic         rst_n,
      raster_if.sink      tim,
      bank_port_if.memory wr,
      bank_port_if.memory rd
   );

   localparam int HALF   = H_ACTIVE / 2;
   localparam int WORDS  = HALF * V_ACTIVE;
   localparam int ADDR_W = $clog2(WORDS);

   word_t bank0 [WORDS];
   word_t bank1 [WORDS];

   // front_sel 0 shows bank0 and fills bank1
   logic              front_sel;
   logic              pending;
   logic              back_free;
   logic              has_frame;
   logic              swap;
   logic              sel_now;
   logic              show_now;
   logic [ADDR_W-1:0] raddr_q;
   logic              rsel_q;
   logic              rshow_q;
   word_t             rdata_q;

   assign swap = tim.frame_start && pending;
   // the read issued in the frame-start cycle already sees the new front bank
   assign sel_now  = front_sel ^ swap;
   assign show_now = has_frame || swap;

   //////////////////////////////////////////////////////////////
   // bank control
   //////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         front_sel <= 1'b0;
         pending   <= 1'b0;
         back_free <= 1'b1;
         has_frame <= 1'b0;
         rshow_q   <= 1'b0;
      end else begin
         rshow_q <= show_now;
         if (wr.frame_done) begin
            // complete frame in the back bank, hold the writer off
            pending   <= 1'b1;
            back_free <= 1'b0;
         end else if (swap) begin
            front_sel <= ~front_sel;
            pending   <= 1'b0;
            back_free <= 1'b1;
            has_frame <= 1'b1;
         end
      end
   end

   // write into whichever bank is at the back
   always_ff @(posedge clk) begin
      if (wr.we) begin
         if (front_sel) begin
            bank0[wr.addr] <= wr.wdata;
         end else begin
            bank1[wr.addr] <= wr.wdata;
         end
      end
   end

   //////////////////////////////////////////////////////////////
   // two-cycle read: register address, then data
   //////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      raddr_q <= rd.addr;
      rsel_q  <= sel_now;
      // black until the first frame has been swapped in
      if (!rshow_q) begin
         rdata_q <= '0;
      end else begin
         rdata_q <= rsel_q ? bank1[raddr_q] : bank0[raddr_q];
      end
   end

   assign rd.rdata     = rdata_q;
   assign rd.back_free = back_free;
   assign wr.back_free = back_free;
   // write side has no read path
   assign wr.rdata     = '0;

endmodule

// ==== src/display_reader.sv ====
// display pipeline: fetches pixel pairs from the front bank, unpacks them, adds bars and drives vga outputs
`timescale 1ns/1ns

module display_reader
   import video_pkg::*;
   #(
      parameter int H_ACTIVE = 16,
      parameter int V_ACTIVE = 6
   ) (
      input  logic            clk,
      input  logic            rst_n,
      raster_if.sink          tim,
      bank_port_if.reader     rd,
      input  logic            test_bars,
      input  logic            video_en,
      output logic [CH_W-1:0] red,
      output logic [CH_W-1:0] green,
      output logic [CH_W-1:0] blue,
      output logic            hsync,
      output logic            vsync,
      output logic            blank
   );

   localparam int HALF   = H_ACTIVE / 2;
   localparam int WORDS  = HALF * V_ACTIVE;
   localparam int ADDR_W = $clog2(WORDS);

   sync_t            sync_d1;
   sync_t            sync_d2;
   logic             par_d1;
   logic             par_d2;
   logic [BAR_W-1:0] bar_d1;
   logic [BAR_W-1:0] bar_d2;
   logic [CH_W-1:0]  bar_ch;
   pixel_t           bar_pix;
   pixel_t           mem_pix;
   pixel_t           out_pix;

   // word of the current line and pair
   // the odd column repeats the even column's address, so one word serves both
   // outside the active region the address is junk and the pixel is blanked
   assign rd.addr = ADDR_W'(tim.vcount * HALF + (tim.hcount >> 1));

   //////////////////////////////////////////////////////////////
   // stages 1 and 2, follow the bank read latency
   //////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sync_d1 <= SYNC_IDLE;
         sync_d2 <= SYNC_IDLE;
      end else begin
         sync_d1 <= tim.sync;
         sync_d2 <= sync_d1;
      end
   end

   // column parity selects hi or lo, bar index from the column
   always_ff @(posedge clk) begin
      par_d1 <= tim.hcount[0];
      par_d2 <= par_d1;
      bar_d1 <= BAR_W'(tim.hcount >> BAR_SHIFT);
      bar_d2 <= bar_d1;
   end

   always_comb begin
      // bar index in the upper bits of each channel
      bar_ch  = {bar_d2, {(CH_W - BAR_W){1'b0}}};
      bar_pix = '{r: bar_ch, g: bar_ch, b: bar_ch};
      mem_pix = par_d2 ? rd.rdata.lo : rd.rdata.hi;
      out_pix = test_bars ? bar_pix : mem_pix;
      if (!video_en || sync_d2.blank) begin
         out_pix = '0;
      end
   end

   //////////////////////////////////////////////////////////////
   // stage 3, output registers
   //////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         red   <= '0;
         green <= '0;
         blue  <= '0;
         hsync <= 1'b1;
         vsync <= 1'b1;
         blank <= 1'b1;
      end else begin
         red   <= out_pix.r;
         green <= out_pix.g;
         blue  <= out_pix.b;
         hsync <= sync_d2.hsync;
         vsync <= sync_d2.vsync;
         blank <= sync_d2.blank;
      end
   end

endmodule

// ==== src/video_top.sv ====
// video path top level: pixel stream in through req/ack, ping-pong frame buffer, vga pixels and syncs out
`timescale 1ns/1ns

module video_top
   import video_pkg::*;
   #(
      parameter int H_ACTIVE     = 16,
      parameter int H_SYNC_START = 18,
      parameter int H_SYNC_END   = 20,
      parameter int H_TOTAL      = 24,
      parameter int V_ACTIVE     = 6,
      parameter int V_SYNC_START = 7,
      parameter int V_SYNC_END   = 8,
      parameter int V_TOTAL      = 10
   ) (
      input  logic            clk,
      input  logic            rst_n,
      // four-phase pixel input, raster order
      input  logic            in_req,
      input  pixel_t          in_pixel,
      output logic            in_ack,
      // board switches
      input  logic            test_bars,
      input  logic            video_en,
      // vga side, all mutually aligned
      output logic [CH_W-1:0] red,
      output logic [CH_W-1:0] green,
      output logic [CH_W-1:0] blue,
      output logic            hsync,
      output logic            vsync,
      output logic            blank
   );

   localparam int HW     = $clog2(H_TOTAL);
   localparam int VW     = $clog2(V_TOTAL);
   localparam int ADDR_W = $clog2((H_ACTIVE / 2) * V_ACTIVE);

   raster_if #(.HW(HW), .VW(VW)) tim ();
   bank_port_if #(.ADDR_W(ADDR_W)) wr_port ();
   bank_port_if #(.ADDR_W(ADDR_W)) rd_port ();

   video_timing #(
      .H_ACTIVE(H_ACTIVE), .H_SYNC_START(H_SYNC_START), .H_SYNC_END(H_SYNC_END),
      .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_SYNC_START(V_SYNC_START),
      .V_SYNC_END(V_SYNC_END), .V_TOTAL(V_TOTAL)
   ) u_timing (
      .clk(clk), .rst_n(rst_n), .tim(tim.source)
   );

   pixel_writer #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_writer (
      .clk(clk), .rst_n(rst_n), .in_req(in_req), .in_pixel(in_pixel),
      .in_ack(in_ack), .wr(wr_port.writer)
   );

   frame_buffer #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_fb (
      .clk(clk), .rst_n(rst_n), .tim(tim.sink),
      .wr(wr_port.memory), .rd(rd_port.memory)
   );

   display_reader #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_reader (
      .clk(clk), .rst_n(rst_n), .tim(tim.sink), .rd(rd_port.reader),
      .test_bars(test_bars), .video_en(video_en),
      .red(red), .green(green), .blue(blue),
      .hsync(hsync), .vsync(vsync), .blank(blank)
   );

endmodule

// ==== bench/tb_clock.sv ====
// testbench clock and reset source: 10 ns clock, active-low reset held for the first cycles
`timescale 1ns/1ns

module tb_clock #(
      parameter int HALF_PERIOD  = 5,
      parameter int RESET_CYCLES = 16
   ) (
      output logic clk,
      output logic rst_n
   );

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // release just after an edge, like the rest of the stimulus
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;
   end

endmodule

// ==== bench/video_assert.sv ====
// concurrent checks on the pixel handshake and the vga syncs, bound into the video top level
`timescale 1ns/1ns

module video_assert
   import video_pkg::*;
   (
      input logic            clk,
      input logic            rst_n,
      input logic            in_req,
      input logic            in_ack,
      input logic [CH_W-1:0] red,
      input logic [CH_W-1:0] green,
      input logic [CH_W-1:0] blue,
      input logic            hsync,
      input logic            vsync,
      input logic            blank
   );

   // number of failed assertions so far
   int failures = 0;

   // ack rises only in answer to a request seen the cycle before
   ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(in_ack) |-> $past(in_req))
   else begin
      failures++;
      $error("in_ack rose without a pending in_req");
   end

   // once acknowledged, ack stays up until the request is withdrawn
   ack_holds: assert property (@(posedge clk) disable iff (!rst_n)
      (in_ack && in_req) |=> in_ack)
   else begin
      failures++;
      $error("in_ack dropped while in_req was still high");
   end

   // syncs only inside the blanking interval
   sync_in_blank: assert property (@(posedge clk) disable iff (!rst_n)
      !blank |-> (hsync && vsync))
   else begin
      failures++;
      $error("hsync or vsync active during the active region");
   end

   // one cycle after a reset edge, every output is idle
   idle_in_reset: assert property (@(posedge clk)
      !rst_n |=> (!in_ack && hsync && vsync && blank
                  && red == '0 && green == '0 && blue == '0))
   else begin
      failures++;
      $error("outputs not idle during reset");
   end

endmodule

bind video_top video_assert u_assert (
   .clk(clk), .rst_n(rst_n), .in_req(in_req), .in_ack(in_ack),
   .red(red), .green(green), .blue(blue),
   .hsync(hsync), .vsync(vsync), .blank(blank)
);

// ==== bench/tb_video_top.sv ====
// top simulation module that drives the video top level through raster, frame buffer and mode tests
`timescale 1ns/1ns

module tb_video_top
   import video_pkg::*;
   ();

   localparam int H_ACTIVE     = 16;
   localparam int H_SYNC_START = 18;
   localparam int H_SYNC_END   = 20;
   localparam int H_TOTAL      = 24;
   localparam int V_ACTIVE     = 6;
   localparam int V_SYNC_START = 7;
   localparam int V_SYNC_END   = 8;
   localparam int V_TOTAL      = 10;

   localparam int NPIX         = H_ACTIVE * V_ACTIVE;
   localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
   // each capture or raster pass waits up to two frames and the run needs about twenty
   localparam int RUN_FRAMES   = 24;
   localparam int WATCHDOG_NS  = RUN_FRAMES * FRAME_CYCLES * 10;
   // back-pressure may last up to a full frame
   localparam int ACK_LIMIT    = 2 * FRAME_CYCLES;

   logic            clk;
   logic            rst_n;
   logic            in_req;
   pixel_t          in_pixel;
   logic            in_ack;
   logic            test_bars;
   logic            video_en;
   logic [CH_W-1:0] red;
   logic [CH_W-1:0] green;
   logic [CH_W-1:0] blue;
   logic            hsync;
   logic            vsync;
   logic            blank;

   int     seed = 32'h602a1b11;
   // reference frame and the frame seen on the outputs in raster order
   pixel_t expected [NPIX];
   pixel_t shown [NPIX];

   tb_clock #(.HALF_PERIOD(5), .RESET_CYCLES(16)) clock_gen (.clk(clk), .rst_n(rst_n));

   video_top #(
      .H_ACTIVE(H_ACTIVE), .H_SYNC_START(H_SYNC_START), .H_SYNC_END(H_SYNC_END),
      .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_SYNC_START(V_SYNC_START),
      .V_SYNC_END(V_SYNC_END), .V_TOTAL(V_TOTAL)
   ) DUT (
      .clk(clk), .rst_n(rst_n), .in_req(in_req), .in_pixel(in_pixel), .in_ack(in_ack),
      .test_bars(test_bars), .video_en(video_en),
      .red(red), .green(green), .blue(blue),
      .hsync(hsync), .vsync(vsync), .blank(blank)
   );

   //////////////////////////////////////////////////////////////
   // failure reporting and compares
   //////////////////////////////////////////////////////////////

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_pixel(input string what, input pixel_t got, input pixel_t exp);
      if (got !== exp) begin
         fail_run($sformatf("Mismatch %s: got 0x%h expected 0x%h", what, got, exp));
      end
   endtask

   task automatic check_count(input string what, input int got, input int exp);
      if (got != exp) begin
         fail_run($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", what, got, exp));
      end
   endtask

   //////////////////////////////////////////////////////////////
   // reference frames built from the display rules
   //////////////////////////////////////////////////////////////

   task automatic make_black();
      for (int i = 0; i < NPIX; i++) begin
         expected[i] = '0;
      end
   endtask

   // r = x, g = y, b = x + y
   task automatic make_gradient();
      for (int y = 0; y < V_ACTIVE; y++) begin
         for (int x = 0; x < H_ACTIVE; x++) begin
            expected[y * H_ACTIVE + x] = '{r: CH_W'(x), g: CH_W'(y), b: CH_W'(x + y)};
         end
      end
   endtask

   task automatic make_random();
      logic [31:0] rnd;
      for (int i = 0; i < NPIX; i++) begin
         rnd = $random(seed);
         expected[i] = rnd[17:0];
      end
   endtask

   // bar index of the column in the top bits of every channel
   task automatic make_bars();
      logic [CH_W-1:0] ch;
      for (int y = 0; y < V_ACTIVE; y++) begin
         for (int x = 0; x < H_ACTIVE; x++) begin
            ch = CH_W'(((x >> BAR_SHIFT) % (1 << BAR_W)) << (CH_W - BAR_W));
            expected[y * H_ACTIVE + x] = '{r: ch, g: ch, b: ch};
         end
      end
   endtask

   //////////////////////////////////////////////////////////////
   // pixel input over the four-phase handshake
   //////////////////////////////////////////////////////////////

   // called 1 ns after an edge and returns 1 ns after the edge where ack matches
   task automatic wait_ack(input logic level, input string what);
      int n;
      n = 0;
      do begin
         @(posedge clk);
         #1;
         n++;
         if (n > ACK_LIMIT) begin
            fail_run(what);
         end
      end while (in_ack !== level);
   endtask

   task automatic send_pixel(input pixel_t p);
      in_req   = 1'b1;
      in_pixel = p;
      wait_ack(1'b1, "in_ack never rose for a pixel request");
      in_req = 1'b0;
      wait_ack(1'b0, "in_ack never fell after the request was withdrawn");
   endtask

   // two cycles per pixel so a frame fits between two vsync pulses
   task automatic send_frame();
      @(posedge clk);
      #1;
      for (int i = 0; i < NPIX; i++) begin
         send_pixel(expected[i]);
      end
   endtask

   //////////////////////////////////////////////////////////////
   // output sampling at the falling edge where outputs are settled
   //////////////////////////////////////////////////////////////

   task automatic wait_vsync_fall();
      logic last;
      logic fell;
      int   n;
      @(negedge clk);
      last = vsync;
      n    = 0;
      do begin
         @(negedge clk);
         n++;
         if (n > 2 * FRAME_CYCLES) begin
            fail_run("vsync did not fall within two frames");
         end
         fell = last && !vsync;
         last = vsync;
      end while (!fell);
   endtask

   // active region following the next vsync pulse
   task automatic capture_frame();
      int n;
      wait_vsync_fall();
      n = 0;
      while (n < NPIX) begin
         @(negedge clk);
         if (!blank) begin
            shown[n] = '{r: red, g: green, b: blue};
            n++;
         end
      end
   endtask

   task automatic compare_frame(input string label);
      int i;
      for (int y = 0; y < V_ACTIVE; y++) begin
         for (int x = 0; x < H_ACTIVE; x++) begin
            i = y * H_ACTIVE + x;
            check_pixel($sformatf("%s pixel (%0d,%0d)", label, x, y), shown[i], expected[i]);
         end
      end
   endtask

   //////////////////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////////////////

   // one frame from vsync fall to vsync fall
   task automatic raster_counts(input string label);
      int   cyc;
      int   h_last;
      int   run;
      int   lines;
      logic hs_q;
      logic bl_q;
      logic vs_q;
      logic done;
      wait_vsync_fall();
      cyc    = 0;
      h_last = -1;
      run    = 0;
      lines  = 0;
      hs_q   = hsync;
      bl_q   = blank;
      vs_q   = vsync;
      done   = 1'b0;
      while (!done) begin
         @(negedge clk);
         cyc++;
         if (cyc > 2 * FRAME_CYCLES) begin
            fail_run("second vsync pulse never arrived");
         end
         if (hs_q && !hsync) begin
            if (h_last >= 0) begin
               check_count($sformatf("%s hsync period", label), cyc - h_last, H_TOTAL);
            end
            h_last = cyc;
         end
         if (!blank) begin
            run++;
         end
         // end of an active run closes one line
         if (!bl_q && blank) begin
            check_count($sformatf("%s active pixels per line", label), run, H_ACTIVE);
            run = 0;
            lines++;
         end
         done = vs_q && !vsync;
         hs_q = hsync;
         bl_q = blank;
         vs_q = vsync;
      end
      check_count($sformatf("%s vsync period", label), cyc, FRAME_CYCLES);
      check_count($sformatf("%s active lines", label), lines, V_ACTIVE);
   endtask

   task automatic empty_buffer_black();
      make_black();
      capture_frame();
      compare_frame("empty buffer");
   endtask

   task automatic gradient_frame_shown();
      make_gradient();
      wait_vsync_fall();
      send_frame();
      capture_frame();
      compare_frame("gradient");
   endtask

   // with the back bank full the next frame's first pixel waits for the swap
   task automatic ping_pong_hold_off();
      logic [31:0] rnd;
      logic        seen_vsync;
      int          n;
      make_random();
      wait_vsync_fall();
      send_frame();
      rnd        = $random(seed);
      in_req     = 1'b1;
      in_pixel   = rnd[17:0];
      seen_vsync = 1'b0;
      n          = 0;
      do begin
         @(posedge clk);
         #1;
         n++;
         if (n > ACK_LIMIT) begin
            fail_run("in_ack never rose after the back bank was released");
         end
         if (!vsync) begin
            seen_vsync = 1'b1;
         end
      end while (!in_ack);
      if (!seen_vsync) begin
         fail_run("in_ack rose for the third frame before any vsync pulse");
      end
      in_req = 1'b0;
      wait_ack(1'b0, "in_ack never fell after the held request");
      capture_frame();
      compare_frame("random");
   endtask

   task automatic display_modes();
      @(posedge clk);
      #1;
      test_bars = 1'b1;
      make_bars();
      capture_frame();
      compare_frame("test bars");
      @(posedge clk);
      #1;
      test_bars = 1'b0;
      video_en  = 1'b0;
      make_black();
      capture_frame();
      compare_frame("video disabled");
      raster_counts("video disabled");
      @(posedge clk);
      #1;
      video_en = 1'b1;
   endtask

   //////////////////////////////////////////////////////////////
   // sequence and watchdog
   //////////////////////////////////////////////////////////////

   initial begin
      in_req    = 1'b0;
      in_pixel  = '0;
      test_bars = 1'b0;
      video_en  = 1'b1;
      wait (rst_n === 1'b1);
      @(posedge clk);
      #1;
      raster_counts("raster");
      empty_buffer_black();
      gradient_frame_shown();
      ping_pong_hold_off();
      display_modes();
      if (DUT.u_assert.failures == 0) begin
         $display("Everything OK");
         $finish;
      end else begin
         fail_run($sformatf("%0d assertion failures", DUT.u_assert.failures));
      end
   end

   // a failed bound assertion ends the run at once
   initial begin
      wait (DUT.u_assert.failures != 0);
      fail_run("a bound assertion on the handshake, syncs or reset state failed");
   end

   initial begin
      #(WATCHDOG_NS);
      fail_run("timeout, the tests did not finish in time");
   end

endmodule

// ==== tb.f ====
src/video_pkg.sv
src/video_if.sv
src/video_timing.sv
src/pixel_writer.sv
src/frame_buffer.sv
src/display_reader.sv
src/video_top.sv
bench/tb_clock.sv
bench/video_assert.sv
bench/tb_video_top.sv
